//--- all.f
+incdir+verif
design/trdb_isa_pkg.sv
design/trdb_pkt_pkg.sv
design/trdb_retire_stage.sv
design/trdb_branch_map.sv
design/trdb_priority.sv
design/trdb_packet_emitter.sv
design/trdb_packet_fifo.sv
design/trace_debugger.sv
verif/tb_trace_debugger.sv

//--- design/trace_debugger.sv
`timescale 1ns/1ns

module trace_debugger
    import trdb_isa_pkg::*;
    import trdb_pkt_pkg::*;
(
    input  logic       clk_gated,
    input  logic       rst_ni,
    input  retire_t    retire_i,
    input  trdb_cfg_t  cfg_i,
    input  logic       stall_i,
    output trace_pkt_t packet_o,
    output logic       packet_valid_o,
    output logic       overflow_o
);

    phase_t                phase;
    logic                  branch_valid;
    logic                  branch_taken;
    logic [BMAP_LEN-1:0]   bmap;
    logic [BMAP_CNT_W-1:0] bmap_cnt;
    logic                  bmap_full;
    logic                  bmap_flush;
    logic                  emit;
    pkt_format_e           format;
    trace_pkt_t            pkt;
    logic                  pkt_push;

    trdb_retire_stage i_trdb_retire_stage (
        .clk_gated      (clk_gated),
        .rst_ni         (rst_ni),
        .retire_i       (retire_i),
        .cfg_i          (cfg_i),
        .phase_o        (phase),
        .branch_valid_o (branch_valid),
        .branch_taken_o (branch_taken)
    );

    trdb_branch_map i_trdb_branch_map (
        .clk_gated (clk_gated),
        .rst_ni    (rst_ni),
        .valid_i   (branch_valid),
        .taken_i   (branch_taken),
        .flush_i   (bmap_flush),
        .map_o     (bmap),
        .count_o   (bmap_cnt),
        .full_o    (bmap_full),
        .empty_o   ()
    );

    trdb_priority i_trdb_priority (
        .phase_i     (phase),
        .bmap_full_i (bmap_full),
        .emit_o      (emit),
        .format_o    (format),
        .flush_o     (bmap_flush)
    );

    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_gated   (clk_gated),
        .rst_ni      (rst_ni),
        .cfg_i       (cfg_i),
        .phase_i     (phase),
        .emit_i      (emit),
        .format_i    (format),
        .bmap_i      (bmap),
        .bmap_cnt_i  (bmap_cnt),
        .pkt_o       (pkt),
        .pkt_valid_o (pkt_push)
    );

    trdb_packet_fifo i_trdb_packet_fifo (
        .clk_gated   (clk_gated),
        .rst_ni      (rst_ni),
        .push_i      (pkt_push),
        .pkt_i       (pkt),
        .stall_i     (stall_i),
        .pkt_o       (packet_o),
        .pkt_valid_o (packet_valid_o),
        .overflow_o  (overflow_o)
    );

endmodule

//--- design/trdb_branch_map.sv
`timescale 1ns/1ns

module trdb_branch_map
    import trdb_pkt_pkg::*;
(
    input  logic                  clk_gated,
    input  logic                  rst_ni,
    input  logic                  valid_i,
    input  logic                  taken_i,
    input  logic                  flush_i,
    output logic [BMAP_LEN-1:0]   map_o,
    output logic [BMAP_CNT_W-1:0] count_o,
    output logic                  full_o,
    output logic                  empty_o
);

    logic [BMAP_LEN-1:0]   map_q;
    logic [BMAP_CNT_W-1:0] cnt_q;

    // reported view already holds the branch of this cycle
    always_comb begin
        map_o   = map_q;
        count_o = cnt_q;
        if (valid_i) begin
            // not taken is recorded as 1
            map_o[cnt_q] = !taken_i;
            count_o      = cnt_q + 1'b1;
        end
    end

    assign full_o  = count_o == BMAP_CNT_W'(BMAP_LEN);
    assign empty_o = count_o == '0;

    // the current branch leaves with the flushed packet
    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            map_q <= '0;
            cnt_q <= '0;
        end else if (flush_i) begin
            map_q <= '0;
            cnt_q <= '0;
        end else begin
            map_q <= map_o;
            cnt_q <= count_o;
        end
    end

    // a stored full map has no free bit left for another branch
    a_no_write_when_full: assert property (@(posedge clk_gated) disable iff (!rst_ni)
        cnt_q == BMAP_CNT_W'(BMAP_LEN) && !flush_i |-> !valid_i)
        else $error("branch written into a full map without a flush");

endmodule

//--- design/trdb_isa_pkg.sv
package trdb_isa_pkg;

    localparam int unsigned XLEN     = 32;
    localparam int unsigned ILEN     = 32;
    localparam int unsigned CAUSELEN = 5;

    // privilege levels as the core encodes them
    typedef enum logic [1:0] {
        priv_user       = 2'b00,
        priv_supervisor = 2'b01,
        priv_machine    = 2'b11
    } priv_e;

    // conditional branches with the pulp immediate compares last
    localparam logic [31:0] MASK_BEQ       = 32'h0000_707f;
    localparam logic [31:0] MATCH_BEQ      = 32'h0000_0063;
    localparam logic [31:0] MASK_BNE       = 32'h0000_707f;
    localparam logic [31:0] MATCH_BNE      = 32'h0000_1063;
    localparam logic [31:0] MASK_BLT       = 32'h0000_707f;
    localparam logic [31:0] MATCH_BLT      = 32'h0000_4063;
    localparam logic [31:0] MASK_BGE       = 32'h0000_707f;
    localparam logic [31:0] MATCH_BGE      = 32'h0000_5063;
    localparam logic [31:0] MASK_BLTU      = 32'h0000_707f;
    localparam logic [31:0] MATCH_BLTU     = 32'h0000_6063;
    localparam logic [31:0] MASK_BGEU      = 32'h0000_707f;
    localparam logic [31:0] MATCH_BGEU     = 32'h0000_7063;
    localparam logic [31:0] MASK_P_BNEIMM  = 32'h0000_707f;
    localparam logic [31:0] MATCH_P_BNEIMM = 32'h0000_3063;
    localparam logic [31:0] MASK_P_BEQIMM  = 32'h0000_707f;
    localparam logic [31:0] MATCH_P_BEQIMM = 32'h0000_2063;

    // jumps whose target can not be read from the executable
    localparam logic [31:0] MASK_JALR      = 32'h0000_707f;
    localparam logic [31:0] MATCH_JALR     = 32'h0000_0067;
    localparam logic [31:0] MASK_MRET      = 32'hffff_ffff;
    localparam logic [31:0] MATCH_MRET     = 32'h3020_0073;
    localparam logic [31:0] MASK_SRET      = 32'hffff_ffff;
    localparam logic [31:0] MATCH_SRET     = 32'h1020_0073;
    localparam logic [31:0] MASK_URET      = 32'hffff_ffff;
    localparam logic [31:0] MATCH_URET     = 32'h0020_0073;

    // one retired instruction as reported by the core
    typedef struct packed {
        logic                valid;
        logic                exception;
        logic                interrupt;
        logic [CAUSELEN-1:0] cause;
        priv_e               priv;
        logic [XLEN-1:0]     iaddr;
        logic [ILEN-1:0]     instr;
        logic                compressed;
    } retire_t;

endpackage

//--- design/trdb_packet_emitter.sv
`timescale 1ns/1ns

module trdb_packet_emitter
    import trdb_isa_pkg::*;
    import trdb_pkt_pkg::*;
(
    input  logic                  clk_gated,
    input  logic                  rst_ni,
    input  trdb_cfg_t             cfg_i,
    input  phase_t                phase_i,
    input  logic                  emit_i,
    input  pkt_format_e           format_i,
    input  logic [BMAP_LEN-1:0]   bmap_i,
    input  logic [BMAP_CNT_W-1:0] bmap_cnt_i,
    output trace_pkt_t            pkt_o,
    output logic                  pkt_valid_o
);

    trace_pkt_t      pkt_d;
    trace_pkt_t      pkt_q;
    logic            pkt_valid_q;
    logic [XLEN-1:0] last_addr_q;
    logic            has_addr;
    logic            use_diff;

    assign has_addr = format_i != fmt_bmap_full;
    // start and exception packets resync the decoder with a full address
    assign use_diff = format_i == fmt_addr && !cfg_i.full_addr;

    always_comb begin
        pkt_d            = '0;
        pkt_d.format     = format_i;
        pkt_d.branch_cnt = bmap_cnt_i;
        pkt_d.branch_map = bmap_i;
        pkt_d.priv       = phase_i.tc_priv;
        if (has_addr) begin
            pkt_d.addr_diff = use_diff;
            if (use_diff) begin
                pkt_d.addr = phase_i.tc_iaddr - last_addr_q;
            end else begin
                pkt_d.addr = phase_i.tc_iaddr;
            end
        end
        if (format_i == fmt_exception) begin
            pkt_d.cause     = phase_i.lc_cause;
            pkt_d.interrupt = phase_i.lc_interrupt;
        end
    end

    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_valid_q <= 1'b0;
            last_addr_q <= '0;
        end else begin
            pkt_valid_q <= emit_i;
            // reference point for the next differential address
            if (emit_i && has_addr) begin
                last_addr_q <= phase_i.tc_iaddr;
            end
        end
    end

    always_ff @(posedge clk_gated) begin
        if (emit_i) begin
            pkt_q <= pkt_d;
        end
    end

    assign pkt_o       = pkt_q;
    assign pkt_valid_o = pkt_valid_q;

endmodule

//--- design/trdb_packet_fifo.sv
`timescale 1ns/1ns

module trdb_packet_fifo
    import trdb_pkt_pkg::*;
(
    input  logic       clk_gated,
    input  logic       rst_ni,
    input  logic       push_i,
    input  trace_pkt_t pkt_i,
    input  logic       stall_i,
    output trace_pkt_t pkt_o,
    output logic       pkt_valid_o,
    output logic       overflow_o
);

    trace_pkt_t            mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] cnt_q;
    trace_pkt_t            out_q;
    logic                  out_valid_q;
    logic                  overflow_q;
    logic                  full;
    logic                  pop;
    logic                  wr_en;

    assign full  = cnt_q == FIFO_CNT_W'(FIFO_DEPTH);
    assign pop   = !stall_i && cnt_q != '0;
    // a slot freed by this cycle's pop can be reused right away
    assign wr_en = push_i && (!full || pop);

    always_ff @(posedge clk_gated) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= pkt_i;
        end
        if (pop) begin
            out_q <= mem_q[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            cnt_q       <= '0;
            out_valid_q <= 1'b0;
            overflow_q  <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            cnt_q       <= cnt_q + FIFO_CNT_W'(wr_en) - FIFO_CNT_W'(pop);
            out_valid_q <= pop;
            // sticky until reset
            if (push_i && !wr_en) begin
                overflow_q <= 1'b1;
            end
        end
    end

    assign pkt_o       = out_q;
    assign pkt_valid_o = out_valid_q;
    assign overflow_o  = overflow_q;

    a_cnt_bound: assert property (@(posedge clk_gated) disable iff (!rst_ni)
        cnt_q <= FIFO_CNT_W'(FIFO_DEPTH))
        else $error("packet queue occupancy above depth");

endmodule

//--- design/trdb_pkt_pkg.sv
package trdb_pkt_pkg;

    import trdb_isa_pkg::*;

    localparam int unsigned BMAP_LEN   = 31;
    localparam int unsigned BMAP_CNT_W = 5;
    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        fmt_bmap_full = 2'b00,
        fmt_addr      = 2'b01,
        fmt_start     = 2'b10,
        fmt_exception = 2'b11
    } pkt_format_e;

    typedef struct packed {
        pkt_format_e           format;
        logic [BMAP_CNT_W-1:0] branch_cnt;
        logic [BMAP_LEN-1:0]   branch_map;
        logic [XLEN-1:0]       addr;
        logic                  addr_diff;
        priv_e                 priv;
        logic [CAUSELEN-1:0]   cause;
        logic                  interrupt;
    } trace_pkt_t;

    typedef struct packed {
        logic enable;
        logic full_addr;
        logic machine_only;
    } trdb_cfg_t;

    // history view shared by the priority and the emitter
    typedef struct packed {
        logic                tc_valid;
        logic                tc_qualified;
        logic                tc_first_qualified;
        logic [XLEN-1:0]     tc_iaddr;
        priv_e               tc_priv;
        logic [XLEN-1:0]     nc_iaddr;
        logic                lc_exception;
        logic                lc_interrupt;
        logic [CAUSELEN-1:0] lc_cause;
        logic                lc_u_discontinuity;
    } phase_t;

endpackage

//--- design/trdb_priority.sv
`timescale 1ns/1ns

module trdb_priority
    import trdb_pkt_pkg::*;
(
    input  phase_t      phase_i,
    input  logic        bmap_full_i,
    output logic        emit_o,
    output pkt_format_e format_o,
    output logic        flush_o
);

    logic active;

    // only qualified instructions on a retiring cycle can trigger
    assign active = phase_i.tc_valid && phase_i.tc_qualified;

    always_comb begin
        emit_o   = 1'b0;
        format_o = fmt_bmap_full;
        if (active) begin
            if (phase_i.lc_exception) begin
                // tc is the first instruction of the handler
                emit_o   = 1'b1;
                format_o = fmt_exception;
            end else if (phase_i.tc_first_qualified) begin
                emit_o   = 1'b1;
                format_o = fmt_start;
            end else if (phase_i.lc_u_discontinuity) begin
                // tc is the jump target
                emit_o   = 1'b1;
                format_o = fmt_addr;
            end else if (bmap_full_i) begin
                emit_o   = 1'b1;
                format_o = fmt_bmap_full;
            end
        end
    end

    // every packet carries the pending branches
    assign flush_o = emit_o;

endmodule

//--- design/trdb_retire_stage.sv
`timescale 1ns/1ns

module trdb_retire_stage
    import trdb_isa_pkg::*;
    import trdb_pkt_pkg::*;
(
    input  logic      clk_gated,
    input  logic      rst_ni,
    input  retire_t   retire_i,
    input  trdb_cfg_t cfg_i,
    output phase_t    phase_o,
    output logic      branch_valid_o,
    output logic      branch_taken_o
);

    retire_t             ret_q;
    logic                tc_valid;
    logic                nc_qualified;
    logic                nc_is_branch;
    logic                nc_u_disc;

    // this cycle
    logic                tc_qualified_q;
    logic                tc_exception_q;
    logic                tc_u_disc_q;
    logic                tc_is_branch_q;
    priv_e               tc_priv_q;
    logic                tc_interrupt_q;
    logic [CAUSELEN-1:0] tc_cause_q;
    logic                tc_compressed_q;
    logic [XLEN-1:0]     tc_iaddr_q;

    // last cycle
    logic                lc_qualified_q;
    logic                lc_exception_q;
    logic                lc_u_disc_q;
    logic                lc_interrupt_q;
    logic [CAUSELEN-1:0] lc_cause_q;

    // keep the core timing paths short
    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            ret_q <= '0;
        end else begin
            ret_q <= retire_i;
        end
    end

    // next cycle decode straight from the registered core signals
    always_comb begin
        nc_qualified = cfg_i.enable && ret_q.valid &&
                       (!cfg_i.machine_only || ret_q.priv == priv_machine);
        nc_is_branch = ((ret_q.instr & MASK_BEQ) == MATCH_BEQ) ||
                       ((ret_q.instr & MASK_BNE) == MATCH_BNE) ||
                       ((ret_q.instr & MASK_BLT) == MATCH_BLT) ||
                       ((ret_q.instr & MASK_BGE) == MATCH_BGE) ||
                       ((ret_q.instr & MASK_BLTU) == MATCH_BLTU) ||
                       ((ret_q.instr & MASK_BGEU) == MATCH_BGEU) ||
                       ((ret_q.instr & MASK_P_BNEIMM) == MATCH_P_BNEIMM) ||
                       ((ret_q.instr & MASK_P_BEQIMM) == MATCH_P_BEQIMM);
        nc_u_disc    = ((ret_q.instr & MASK_JALR) == MATCH_JALR) ||
                       ((ret_q.instr & MASK_MRET) == MATCH_MRET) ||
                       ((ret_q.instr & MASK_SRET) == MATCH_SRET) ||
                       ((ret_q.instr & MASK_URET) == MATCH_URET);
    end

    // history only moves when the core retired something
    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            tc_qualified_q <= 1'b0;
            tc_exception_q <= 1'b0;
            tc_u_disc_q    <= 1'b0;
            tc_is_branch_q <= 1'b0;
            tc_priv_q      <= priv_machine;
            lc_qualified_q <= 1'b0;
            lc_exception_q <= 1'b0;
            lc_u_disc_q    <= 1'b0;
        end else if (ret_q.valid) begin
            tc_qualified_q <= nc_qualified;
            tc_exception_q <= ret_q.exception;
            tc_u_disc_q    <= nc_u_disc;
            tc_is_branch_q <= nc_is_branch;
            tc_priv_q      <= ret_q.priv;
            lc_qualified_q <= tc_qualified_q;
            lc_exception_q <= tc_exception_q;
            lc_u_disc_q    <= tc_u_disc_q;
        end
    end

    always_ff @(posedge clk_gated) begin
        if (ret_q.valid) begin
            tc_interrupt_q  <= ret_q.interrupt;
            tc_cause_q      <= ret_q.cause;
            tc_compressed_q <= ret_q.compressed;
            tc_iaddr_q      <= ret_q.iaddr;
            lc_interrupt_q  <= tc_interrupt_q;
            lc_cause_q      <= tc_cause_q;
        end
    end

    assign tc_valid = ret_q.valid && cfg_i.enable;

    always_comb begin
        phase_o.tc_valid           = tc_valid;
        phase_o.tc_qualified       = tc_qualified_q;
        phase_o.tc_first_qualified = tc_qualified_q && !lc_qualified_q;
        phase_o.tc_iaddr           = tc_iaddr_q;
        phase_o.tc_priv            = tc_priv_q;
        phase_o.nc_iaddr           = ret_q.iaddr;
        phase_o.lc_exception       = lc_exception_q;
        phase_o.lc_interrupt       = lc_interrupt_q;
        phase_o.lc_cause           = lc_cause_q;
        phase_o.lc_u_discontinuity = lc_u_disc_q;
    end

    // taken when the next address is not the fall-through one
    always_comb begin
        if (tc_compressed_q) begin
            branch_taken_o = ret_q.iaddr != tc_iaddr_q + XLEN'(2);
        end else begin
            branch_taken_o = ret_q.iaddr != tc_iaddr_q + XLEN'(4);
        end
    end

    assign branch_valid_o = tc_valid && tc_qualified_q && tc_is_branch_q;

    // the core never traps on a conditional branch
    a_no_branch_exception: assert property (@(posedge clk_gated) disable iff (!rst_ni)
        retire_i.valid && retire_i.exception |=> !nc_is_branch)
        else $error("exception reported on a branch instruction");

endmodule

//--- verif/trdb_checks.svh
`ifndef TRDB_CHECKS_SVH
`define TRDB_CHECKS_SVH

int err_cnt   = 0;
int check_cnt = 0;

// one field of a packet shown in hex on a mismatch
task automatic compare_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
        $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic check_format(input string name, input pkt_format_e got,
                            input pkt_format_e exp);
    check_cnt++;
    if (got !== exp) begin
        $display("error %s.format got 0x%0h expected 0x%0h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic check_pkt(input int idx, input trace_pkt_t got, input trace_pkt_t exp);
    string name;
    name = $sformatf("packet_o[%0d]", idx);
    check_format(name, got.format, exp.format);
    compare_field({name, ".branch_cnt"}, 32'(got.branch_cnt), 32'(exp.branch_cnt));
    compare_field({name, ".branch_map"}, 32'(got.branch_map), 32'(exp.branch_map));
    compare_field({name, ".addr"}, got.addr, exp.addr);
    compare_field({name, ".addr_diff"}, 32'(got.addr_diff), 32'(exp.addr_diff));
    compare_field({name, ".priv"}, 32'(got.priv), 32'(exp.priv));
    compare_field({name, ".cause"}, 32'(got.cause), 32'(exp.cause));
    compare_field({name, ".interrupt"}, 32'(got.interrupt), 32'(exp.interrupt));
endtask

task automatic check_overflow(input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
        $display("error overflow_o got 0x%0h expected 0x%0h", got, exp);
        err_cnt++;
    end
endtask

`endif

//--- verif/tb_trace_debugger.sv
`timescale 1ns/1ns

module tb_trace_debugger
    import trdb_isa_pkg::*;
    import trdb_pkt_pkg::*;
();

    logic       clk_gated;
    logic       rst_ni;
    retire_t    retire_i;
    trdb_cfg_t  cfg_i;
    logic       stall_i;
    trace_pkt_t packet_o;
    logic       packet_valid_o;
    logic       overflow_o;

    // parsed pattern file as flat queues that each test indexes into
    retire_t    stim_q[$];
    trace_pkt_t exp_q[$];
    trace_pkt_t rx_q[$];
    string      t_name[$];
    trdb_cfg_t  t_cfg[$];
    logic       t_stall[$];
    logic       t_ovf[$];
    int         t_stim_first[$];
    int         t_exp_first[$];
    logic [31:0] lfsr_state = 32'hd81f1365;
    logic       parsed = 1'b0;

    `include "trdb_checks.svh"

    trace_debugger u_dut (
        .clk_gated      (clk_gated),
        .rst_ni         (rst_ni),
        .retire_i       (retire_i),
        .cfg_i          (cfg_i),
        .stall_i        (stall_i),
        .packet_o       (packet_o),
        .packet_valid_o (packet_valid_o),
        .overflow_o     (overflow_o)
    );

    initial clk_gated = 1'b0;
    always #5 clk_gated = ~clk_gated;

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk_gated) begin
        if (rst_ni && packet_valid_o) begin
            rx_q.push_back(packet_o);
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_gap(output int gap);
        lfsr_state = lfsr_step(lfsr_state);
        gap        = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        gap        = gap * 2 + lfsr_state[0];
    endtask

    task automatic read_patterns(output bit ok);
        int          fd;
        int          n;
        string       tok;
        string       line;
        string       name;
        logic [31:0] f[8];
        retire_t     r;
        trace_pkt_t  p;
        ok = 1'b1;
        fd = $fopen("verif/trdb_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file verif/trdb_patterns.txt could not be opened");
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) break;
            if (tok == "#") begin
                n = $fgets(line, fd);
            end else if (tok == "test") begin
                n = $fscanf(fd, " %s %h %h", name, f[0], f[1]);
                t_name.push_back(name);
                t_cfg.push_back(trdb_cfg_t'(f[0][2:0]));
                t_stall.push_back(f[1][0]);
                t_stim_first.push_back(stim_q.size());
                t_exp_first.push_back(exp_q.size());
            end else if (tok == "r") begin
                n = $fscanf(fd, " %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                r            = '0;
                r.valid      = f[0][0];
                r.exception  = f[1][0];
                r.interrupt  = f[2][0];
                r.cause      = f[3][CAUSELEN-1:0];
                r.priv       = priv_e'(f[4][1:0]);
                r.iaddr      = f[5];
                r.instr      = f[6];
                r.compressed = f[7][0];
                stim_q.push_back(r);
            end else if (tok == "b") begin
                // run of beq where a set bit j sends branch j 0x40 ahead
                n = $fscanf(fd, " %d %h %h", f[0], f[1], f[2]);
                for (int j = 0; j < f[0] + 2; j++) begin
                    r       = '0;
                    r.valid = 1'b1;
                    r.priv  = priv_machine;
                    r.iaddr = f[1];
                    r.instr = (j < f[0]) ? 32'h0000_0063 : 32'h0000_0013;
                    stim_q.push_back(r);
                    f[1] = (j < f[0] && f[2][j]) ? f[1] + 32'h40 : f[1] + 32'h4;
                end
            end else if (tok == "p") begin
                n = $fscanf(fd, " %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                p.format     = pkt_format_e'(f[0][1:0]);
                p.branch_cnt = f[1][BMAP_CNT_W-1:0];
                p.branch_map = f[2][BMAP_LEN-1:0];
                p.addr       = f[3];
                p.addr_diff  = f[4][0];
                p.priv       = priv_e'(f[5][1:0]);
                p.cause      = f[6][CAUSELEN-1:0];
                p.interrupt  = f[7][0];
                exp_q.push_back(p);
            end else if (tok == "o") begin
                n = $fscanf(fd, " %h", f[0]);
                t_ovf.push_back(f[0][0]);
            end else begin
                $display("unknown record type %s in pattern file", tok);
                ok = 1'b0;
            end
        end
        $fclose(fd);
        if (t_ovf.size() != t_name.size()) begin
            $display("pattern file has a test without its closing overflow record");
            ok = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        int stim_end;
        int exp_end;
        int gap;
        int waited;
        int errs_before;
        errs_before = err_cnt;
        stim_end    = (t + 1 < t_name.size()) ? t_stim_first[t + 1] : stim_q.size();
        exp_end     = (t + 1 < t_name.size()) ? t_exp_first[t + 1] : exp_q.size();
        rst_ni   = 1'b0;
        cfg_i    = t_cfg[t];
        stall_i  = 1'b0;
        retire_i = '0;
        repeat (5) @(posedge clk_gated);
        #1;
        rst_ni = 1'b1;
        rx_q.delete();
        stall_i = t_stall[t];
        for (int k = t_stim_first[t]; k < stim_end; k++) begin
            draw_gap(gap);
            repeat (gap) begin
                @(posedge clk_gated);
                #1;
                retire_i = '0;
            end
            @(posedge clk_gated);
            #1;
            retire_i = stim_q[k];
        end
        @(posedge clk_gated);
        #1;
        retire_i = '0;
        repeat (8) @(posedge clk_gated);
        #1;
        stall_i = 1'b0;
        waited  = 0;
        while (rx_q.size() < exp_end - t_exp_first[t] && waited < 50) begin
            @(posedge clk_gated);
            waited++;
        end
        // give stray packets a chance to show up
        repeat (6) @(posedge clk_gated);
        #1;
        for (int k = t_exp_first[t]; k < exp_end; k++) begin
            if (k - t_exp_first[t] < rx_q.size()) begin
                check_pkt(k - t_exp_first[t], rx_q[k - t_exp_first[t]], exp_q[k]);
            end else begin
                $display("packet %0d never arrived", k - t_exp_first[t]);
                err_cnt++;
            end
        end
        if (rx_q.size() > exp_end - t_exp_first[t]) begin
            $display("%0d more packets arrived than expected",
                     rx_q.size() - (exp_end - t_exp_first[t]));
            err_cnt++;
        end
        check_overflow(overflow_o, t_ovf[t]);
        $display("test %s: %s, %0d packets, %0d errors", t_name[t],
                 (err_cnt == errs_before) ? "passed" : "failed", rx_q.size(),
                 err_cnt - errs_before);
    endtask

    initial begin
        bit ok;
        rst_ni   = 1'b0;
        retire_i = '0;
        cfg_i    = '0;
        stall_i  = 1'b0;
        read_patterns(ok);
        parsed = 1'b1;
        if (!ok) begin
            $display("Something failed");
            $finish;
        end else begin
            for (int t = 0; t < t_name.size(); t++) begin
                run_test(t);
            end
            $display("tests %0d, checks %0d, errors %0d", t_name.size(), check_cnt,
                     err_cnt);
            if (err_cnt == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

    // budget of 20 cycles per stimulus record plus 200
    initial begin
        int limit;
        wait (parsed);
        limit = stim_q.size() * 20 + 200;
        repeat (limit) @(posedge clk_gated);
        $display("simulation hung, no end after %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

endmodule

//--- verif/trdb_patterns.txt
# test name cfg(enable,full_addr,machine_only) stall | r valid exc int cause priv iaddr instr c
# b count addr taken_bits | p fmt cnt map addr diff priv cause int | o overflow
test start 5 0
r 1 0 0 00 0 00001000 00000013 0
r 1 0 0 00 0 00001004 00000013 0
r 1 0 0 00 3 00001008 00000013 0
r 1 0 0 00 3 0000100c 00000013 0
r 1 0 0 00 3 00001010 00000013 0
p 2 00 00000000 00001008 0 3 00 0
o 0
test bmap_full 4 0
r 1 0 0 00 3 00002000 00000013 0
r 1 0 0 00 3 00002004 00000013 0
b 31 00002008 2a5c3e91
p 2 00 00000000 00002000 0 3 00 0
p 0 1f 55a3c16e 00000000 0 3 00 0
o 0
test disc_diff 4 0
r 1 0 0 00 3 00003000 00000013 0
r 1 0 0 00 3 00003004 00000063 0
r 1 0 0 00 3 00003008 00000063 0
r 1 0 0 00 3 00003100 00008067 0
r 1 0 0 00 3 00003200 00000013 0
r 1 0 0 00 3 00003204 00000013 0
r 1 0 0 00 3 00003208 30200073 0
r 1 0 0 00 3 00003480 00000013 0
r 1 0 0 00 3 00003484 00000013 0
r 1 0 0 00 3 00003488 00000013 0
p 2 00 00000000 00003000 0 3 00 0
p 1 02 00000001 00000200 1 3 00 0
p 1 00 00000000 00000280 1 3 00 0
o 0
test disc_full 6 0
r 1 0 0 00 3 00004000 00000013 0
r 1 0 0 00 3 00004004 00008067 0
r 1 0 0 00 3 00004100 00000013 0
r 1 0 0 00 3 00004104 00000013 0
p 2 00 00000000 00004000 0 3 00 0
p 1 00 00000000 00004100 0 3 00 0
o 0
test exception 4 0
r 1 0 0 00 3 00005000 00000013 0
r 1 1 0 05 3 00005004 00002003 0
r 1 0 0 00 3 00000100 00000013 0
r 1 0 0 00 3 00000104 00000013 0
r 1 1 1 0b 3 00000108 00000013 0
r 1 0 0 00 3 00000200 00000013 0
r 1 0 0 00 3 00000204 00000013 0
p 2 00 00000000 00005000 0 3 00 0
p 3 00 00000000 00000100 0 3 05 0
p 3 00 00000000 00000200 0 3 0b 1
o 0
test backpressure 6 1
r 1 0 0 00 3 00006000 00000013 0
r 1 0 0 00 3 00006004 00008067 0
r 1 0 0 00 3 00006100 00008067 0
r 1 0 0 00 3 00006200 00008067 0
r 1 0 0 00 3 00006300 00008067 0
r 1 0 0 00 3 00006400 00008067 0
r 1 0 0 00 3 00006500 00000013 0
r 1 0 0 00 3 00006504 00000013 0
p 2 00 00000000 00006000 0 3 00 0
p 1 00 00000000 00006100 0 3 00 0
p 1 00 00000000 00006200 0 3 00 0
p 1 00 00000000 00006300 0 3 00 0
o 1
